// File: source/divider_consts.svh
`ifndef DIVIDER_CONSTS_SVH
`define DIVIDER_CONSTS_SVH

// Operand widths, quotient shares the dividend width
`define DIVIDEND_WIDTH 32
`define DIVISOR_WIDTH  24

// APB address width
`define APB_ADDR_WIDTH 4

// Register offsets
`define REG_DIVIDEND   4'h0
`define REG_DIVISOR    4'h4
`define REG_CONTROL    4'h8
`define REG_QUOTIENT   4'hC

`endif

// File: source/divider_pkg.sv
`include "divider_consts.svh"

package divider_pkg;

    typedef logic [`DIVIDEND_WIDTH-1:0]   dividend_t;
    typedef logic [`DIVISOR_WIDTH-1:0]    divisor_t;
    typedef logic [`DIVIDEND_WIDTH-1:0]   quotient_t;
    typedef logic [`DIVIDEND_WIDTH-1:0]   magnitude_t;
    // Double width, remainder in flight or aligned divisor
    typedef logic [2*`DIVIDEND_WIDTH-1:0] partial_t;
    typedef logic [`APB_ADDR_WIDTH-1:0]   apb_addr_t;
    typedef logic [31:0]                  apb_data_t;
    // Bit 0 busy, bit 1 done, bit 2 divide by zero
    typedef logic [2:0]                   status_t;

    typedef enum logic [1:0] {state_idle, state_running, state_finished} control_state_t;

endpackage

// File: source/operand_condition.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module operand_condition (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    input  divider_pkg::dividend_t dividend,
    input  divider_pkg::divisor_t  divisor,
    output logic                   out_valid,
    output logic                   out_sign,
    output divider_pkg::partial_t  out_remainder,
    output divider_pkg::partial_t  out_divisor
);

    divider_pkg::magnitude_t    dividend_magnitude;
    logic [`DIVISOR_WIDTH-1:0]  divisor_magnitude;

    // Two's complement magnitudes, most negative values still fit unsigned
    assign dividend_magnitude = dividend[`DIVIDEND_WIDTH-1] ? ~dividend + 1'b1 : dividend;
    assign divisor_magnitude  = divisor[`DIVISOR_WIDTH-1] ? ~divisor + 1'b1 : divisor;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Divisor sits in the upper half so each stage compares one aligned bit
    always_ff @(posedge clock) begin
        out_sign      <= dividend[`DIVIDEND_WIDTH-1] ^ divisor[`DIVISOR_WIDTH-1];
        out_remainder <= {{`DIVIDEND_WIDTH{1'b0}}, dividend_magnitude};
        out_divisor   <= {{(`DIVIDEND_WIDTH-`DIVISOR_WIDTH){1'b0}}, divisor_magnitude,
                          {`DIVIDEND_WIDTH{1'b0}}};
    end

endmodule

// File: source/divide_stages.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module divide_stages (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    in_valid,
    input  logic                    in_sign,
    input  divider_pkg::partial_t   in_remainder,
    input  divider_pkg::partial_t   in_divisor,
    output logic                    out_valid,
    output logic                    out_sign,
    output divider_pkg::magnitude_t out_quotient
);

    // Index 0 is the stage input, index i+1 the register of stage i
    wire                          valid_chain     [0:`DIVIDEND_WIDTH];
    wire                          sign_chain      [0:`DIVIDEND_WIDTH];
    wire divider_pkg::partial_t   remainder_chain [0:`DIVIDEND_WIDTH];
    wire divider_pkg::partial_t   divisor_chain   [0:`DIVIDEND_WIDTH];
    wire divider_pkg::magnitude_t quotient_chain  [0:`DIVIDEND_WIDTH];

    assign valid_chain[0]     = in_valid;
    assign sign_chain[0]      = in_sign;
    assign remainder_chain[0] = in_remainder;
    assign divisor_chain[0]   = in_divisor;
    assign quotient_chain[0]  = '0;

    genvar i;
    generate
        for (i = 0; i < `DIVIDEND_WIDTH; i = i + 1) begin : stage
            divider_pkg::partial_t   shifted;
            logic                    fits;
            logic                    valid_r;
            logic                    sign_r;
            divider_pkg::partial_t   remainder_r;
            divider_pkg::partial_t   divisor_r;
            divider_pkg::magnitude_t quotient_r;

            // Shift then trial subtract
            assign shifted = remainder_chain[i] << 1;
            assign fits    = shifted >= divisor_chain[i];

            always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                    valid_r <= 1'b0;
                end else begin
                    valid_r <= valid_chain[i];
                end
            end

            always_ff @(posedge clock) begin
                sign_r      <= sign_chain[i];
                divisor_r   <= divisor_chain[i];
                remainder_r <= fits ? shifted - divisor_chain[i] : shifted;
                quotient_r  <= {quotient_chain[i][`DIVIDEND_WIDTH-2:0], fits};
            end

            assign valid_chain[i+1]     = valid_r;
            assign sign_chain[i+1]      = sign_r;
            assign remainder_chain[i+1] = remainder_r;
            assign divisor_chain[i+1]   = divisor_r;
            assign quotient_chain[i+1]  = quotient_r;
        end
    endgenerate

    assign out_valid    = valid_chain[`DIVIDEND_WIDTH];
    assign out_sign     = sign_chain[`DIVIDEND_WIDTH];
    assign out_quotient = quotient_chain[`DIVIDEND_WIDTH];

endmodule

// File: source/quotient_restore.sv
`timescale 1ns/1ps

module quotient_restore (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    in_valid,
    input  logic                    in_sign,
    input  divider_pkg::magnitude_t in_quotient,
    output logic                    out_valid,
    output divider_pkg::quotient_t  out_quotient
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Negate when the operand signs differ, gives truncation toward zero
    always_ff @(posedge clock) begin
        if (in_sign) begin
            out_quotient <= ~in_quotient + 1'b1;
        end else begin
            out_quotient <= in_quotient;
        end
    end

endmodule

// File: source/divider_control.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module divider_control (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  divider_pkg::apb_addr_t paddr,
    input  divider_pkg::apb_data_t pwdata,
    output divider_pkg::apb_data_t prdata,
    output logic                   issue,
    output divider_pkg::dividend_t issue_dividend,
    output divider_pkg::divisor_t  issue_divisor,
    input  logic                   result_valid,
    input  divider_pkg::quotient_t result
);

    divider_pkg::dividend_t      dividend_q;
    divider_pkg::divisor_t       divisor_q;
    divider_pkg::quotient_t      quotient_q;
    divider_pkg::control_state_t state;
    divider_pkg::status_t        status;
    logic                        div_zero;
    logic                        apb_write;
    logic                        start;

    // Write completes in the access phase
    assign apb_write = psel && penable && pwrite;

    // Start is dropped while a job is still in the pipeline
    assign start = apb_write && (paddr == `REG_CONTROL) && pwdata[0]
                   && (state != divider_pkg::state_running);

    // Operand registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dividend_q <= '0;
            divisor_q  <= '0;
        end else if (apb_write) begin
            if (paddr == `REG_DIVIDEND) begin
                dividend_q <= pwdata;
            end
            if (paddr == `REG_DIVISOR) begin
                divisor_q <= pwdata[`DIVISOR_WIDTH-1:0];
            end
        end
    end

    // Job FSM
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= divider_pkg::state_idle;
            div_zero   <= 1'b0;
            issue      <= 1'b0;
            quotient_q <= '0;
        end else begin
            issue <= 1'b0;
            if (start) begin
                if (divisor_q == '0) begin
                    // Zero divisor never enters the datapath
                    state      <= divider_pkg::state_finished;
                    div_zero   <= 1'b1;
                    quotient_q <= '0;
                end else begin
                    state    <= divider_pkg::state_running;
                    div_zero <= 1'b0;
                    issue    <= 1'b1;
                end
            end else if ((state == divider_pkg::state_running) && result_valid) begin
                state      <= divider_pkg::state_finished;
                quotient_q <= result;
            end
        end
    end

    // Operands stay stable for the issue cycle
    assign issue_dividend = dividend_q;
    assign issue_divisor  = divisor_q;

    // Busy, done, divide by zero
    assign status = {div_zero,
                     state == divider_pkg::state_finished,
                     state == divider_pkg::state_running};

    // Read mux
    always_comb begin
        prdata = '0;
        if (psel) begin
            case (paddr)
                `REG_DIVIDEND: begin
                    prdata = dividend_q;
                end
                `REG_DIVISOR: begin
                    prdata = divider_pkg::apb_data_t'(divisor_q);
                end
                `REG_CONTROL: begin
                    prdata = divider_pkg::apb_data_t'(status);
                end
                `REG_QUOTIENT: begin
                    prdata = quotient_q;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

// File: source/divider_top.sv
`timescale 1ns/1ps

module divider_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  divider_pkg::apb_addr_t paddr,
    input  divider_pkg::apb_data_t pwdata,
    output divider_pkg::apb_data_t prdata
);

    logic                    issue;
    divider_pkg::dividend_t  issue_dividend;
    divider_pkg::divisor_t   issue_divisor;
    logic                    cond_valid;
    logic                    cond_sign;
    divider_pkg::partial_t   cond_remainder;
    divider_pkg::partial_t   cond_divisor;
    logic                    stage_valid;
    logic                    stage_sign;
    divider_pkg::magnitude_t stage_quotient;
    logic                    result_valid;
    divider_pkg::quotient_t  result;

    divider_control u_control (
        .clock          (clock),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .issue          (issue),
        .issue_dividend (issue_dividend),
        .issue_divisor  (issue_divisor),
        .result_valid   (result_valid),
        .result         (result)
    );

    // Datapath, one cycle in, one per bit, one out
    operand_condition u_condition (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (issue),
        .dividend      (issue_dividend),
        .divisor       (issue_divisor),
        .out_valid     (cond_valid),
        .out_sign      (cond_sign),
        .out_remainder (cond_remainder),
        .out_divisor   (cond_divisor)
    );

    divide_stages u_stages (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (cond_valid),
        .in_sign      (cond_sign),
        .in_remainder (cond_remainder),
        .in_divisor   (cond_divisor),
        .out_valid    (stage_valid),
        .out_sign     (stage_sign),
        .out_quotient (stage_quotient)
    );

    quotient_restore u_restore (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (stage_valid),
        .in_sign      (stage_sign),
        .in_quotient  (stage_quotient),
        .out_valid    (result_valid),
        .out_quotient (result)
    );

endmodule

// File: bench/divider_tb.sv
`timescale 1ns/1ps
`include "divider_consts.svh"

module divider_tb;

    logic                   clock;
    logic                   reset;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    divider_pkg::apb_addr_t paddr;
    divider_pkg::apb_data_t pwdata;
    divider_pkg::apb_data_t prdata;

    int          mismatch_count;
    int          timeout_count;
    logic [15:0] lfsr_state;

    // Stimulus table with one entry per job
    divider_pkg::dividend_t row_dividend[$];
    divider_pkg::divisor_t  row_divisor[$];
    divider_pkg::quotient_t row_quotient[$];
    logic                   row_flag[$];

    divider_top DUT (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic apb_write(input divider_pkg::apb_addr_t addr,
                             input divider_pkg::apb_data_t data);
        @(posedge clock);
        psel   <= 1'b1;
        pwrite <= 1'b1;
        paddr  <= addr;
        pwdata <= data;
        @(posedge clock);
        penable <= 1'b1;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input divider_pkg::apb_addr_t addr,
                            output divider_pkg::apb_data_t data);
        @(posedge clock);
        psel   <= 1'b1;
        pwrite <= 1'b0;
        paddr  <= addr;
        @(posedge clock);
        penable <= 1'b1;
        // Sample prdata mid cycle once it has settled
        @(negedge clock);
        data = prdata;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_quotient(input string name, input divider_pkg::quotient_t got,
                                  input divider_pkg::quotient_t expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_status(input string name, input divider_pkg::status_t got,
                                input divider_pkg::status_t expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_operand(input string name, input divider_pkg::apb_data_t got,
                                 input divider_pkg::apb_data_t expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            mismatch_count++;
        end
    endtask

    // Poll status until done or 200 reads
    task automatic wait_done(output divider_pkg::status_t status);
        divider_pkg::apb_data_t data;
        int                     polls;
        polls = 0;
        data  = '0;
        while (!data[1] && polls < 200) begin
            apb_read(`REG_CONTROL, data);
            polls++;
        end
        if (!data[1]) begin
            $display("Timeout: the done bit did not rise after %0d status reads", polls);
            timeout_count++;
        end
        status = data[2:0];
    endtask

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // C style division truncating toward zero
    function automatic divider_pkg::quotient_t reference_quotient(
        input divider_pkg::dividend_t dividend,
        input divider_pkg::divisor_t  divisor);
        longint numerator;
        longint denominator;
        numerator   = longint'($signed(dividend));
        denominator = longint'($signed(divisor));
        if (denominator == 0) begin
            return '0;
        end
        return divider_pkg::quotient_t'(numerator / denominator);
    endfunction

    task automatic add_row(input divider_pkg::dividend_t dividend,
                           input divider_pkg::divisor_t divisor,
                           input divider_pkg::quotient_t quotient, input logic flag);
        row_dividend.push_back(dividend);
        row_divisor.push_back(divisor);
        row_quotient.push_back(quotient);
        row_flag.push_back(flag);
    endtask

    initial begin
        logic [31:0]            bits;
        logic [31:0]            shift;
        divider_pkg::dividend_t dividend;
        divider_pkg::divisor_t  divisor;
        divider_pkg::apb_data_t data;
        divider_pkg::status_t   status;

        reset          = 1'b1;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        mismatch_count = 0;
        timeout_count  = 0;
        lfsr_state     = 16'd40470;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        // Everything reads zero out of reset
        apb_read(`REG_CONTROL, data);
        check_status("status after reset", data[2:0], 3'b000);
        apb_read(`REG_QUOTIENT, data);
        check_quotient("quotient after reset", data, '0);
        apb_read(`REG_DIVIDEND, data);
        check_operand("dividend after reset", data, '0);
        apb_read(`REG_DIVISOR, data);
        check_operand("divisor after reset", data, '0);

        // Divisor reads back only its low 24 bits
        apb_write(`REG_DIVIDEND, 32'h1234_5678);
        apb_write(`REG_DIVISOR, 32'hABCD_EF12);
        apb_read(`REG_DIVIDEND, data);
        check_operand("dividend readback", data, 32'h1234_5678);
        apb_read(`REG_DIVISOR, data);
        check_operand("divisor readback", data, 32'h00CD_EF12);

        // Second start with a zero divisor while busy must not disturb the first job
        apb_write(`REG_DIVIDEND, 32'd1000);
        apb_write(`REG_DIVISOR, 32'd10);
        apb_write(`REG_CONTROL, 32'h1);
        apb_read(`REG_CONTROL, data);
        check_status("status while busy", data[2:0], 3'b001);
        apb_write(`REG_DIVISOR, 32'd0);
        apb_write(`REG_CONTROL, 32'h1);
        wait_done(status);
        check_status("status after restart", status, 3'b010);
        apb_read(`REG_QUOTIENT, data);
        check_quotient("quotient after restart", data, 32'd100);

        // Sign combinations, extremes, zero divisor then a valid job
        add_row(32'd100, 24'd7, 32'd14, 1'b0);
        add_row(32'hFFFF_FF9C, 24'd7, 32'hFFFF_FFF2, 1'b0);
        add_row(32'hFFFF_FF9C, 24'hFF_FFF9, 32'd14, 1'b0);
        add_row(32'd100, 24'hFF_FFF9, 32'hFFFF_FFF2, 1'b0);
        add_row(32'hFFFF_FFF9, 24'd2, 32'hFFFF_FFFD, 1'b0);
        add_row(32'd5, 24'd9, 32'd0, 1'b0);
        add_row(32'h8000_0000, 24'd2, 32'hC000_0000, 1'b0);
        add_row(32'hFFFF_FFFB, 24'd9, 32'd0, 1'b0);
        add_row(32'h8000_0000, 24'd1, 32'h8000_0000, 1'b0);
        add_row(32'h8000_0000, 24'h80_0000, 32'h0000_0100, 1'b0);
        add_row(32'h7FFF_FFFF, 24'hFF_FFFF, 32'h8000_0001, 1'b0);
        add_row(32'h7FFF_FFFF, 24'h7F_FFFF, 32'h0000_0100, 1'b0);
        add_row(32'd1234, 24'd0, 32'd0, 1'b1);
        add_row(32'd1234, 24'd1, 32'd1234, 1'b0);
        for (int n = 0; n < 40; n++) begin
            take_bits(32, bits);
            dividend = bits;
            take_bits(24, bits);
            divisor = bits[23:0];
            take_bits(4, shift);
            // Spread divisor magnitudes
            divisor = $signed(divisor) >>> shift[3:0];
            add_row(dividend, divisor, reference_quotient(dividend, divisor), divisor == '0);
        end

        for (int r = 0; r < row_dividend.size(); r++) begin
            apb_write(`REG_DIVIDEND, row_dividend[r]);
            apb_write(`REG_DIVISOR, divider_pkg::apb_data_t'(row_divisor[r]));
            apb_write(`REG_CONTROL, 32'h1);
            wait_done(status);
            check_status($sformatf("status row %0d", r), status, {row_flag[r], 2'b10});
            apb_read(`REG_QUOTIENT, data);
            check_quotient($sformatf("quotient row %0d", r), data, row_quotient[r]);
        end

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+source
source/divider_pkg.sv
source/operand_condition.sv
source/divide_stages.sv
source/quotient_restore.sv
source/divider_control.sv
source/divider_top.sv
bench/divider_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f filelist.f --top-module divider_tb -o divider_sim
output=$(./obj_dir/divider_sim)
echo "$output"
if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
